/* hdl/rvIsaPkg.sv */
// RV32 instruction set definitions
`default_nettype none

package rvIsaPkg;

	localparam int xlen     = 32; // Data path width
	localparam int regAddrW = 5;  // Register index width

	// Major opcodes, instruction bits [6:0]
	typedef enum logic [6:0] {
		opReg    = 7'b0110011, // OP
		opImm    = 7'b0010011, // OP-IMM
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opBranch = 7'b1100011
	} opcodeE;

	// Bit 3 selects SUB/SRA, low three bits equal funct3
	typedef enum logic [3:0] {
		aluAdd = 4'b0000,
		aluSub = 4'b1000,
		aluSll = 4'b0001,
		aluSlt = 4'b0010,
		aluXor = 4'b0100,
		aluSrl = 4'b0101,
		aluSra = 4'b1101,
		aluOr  = 4'b0110,
		aluAnd = 4'b0111
	} aluOpE;

	// Branch conditions
	localparam logic [2:0] f3Beq = 3'b000;
	localparam logic [2:0] f3Bne = 3'b001;

	localparam logic [2:0] f3Sr  = 3'b101; // SRL/SRA and immediate forms

endpackage

`default_nettype wire

/* hdl/rvPipePkg.sv */
// Pipeline definitions
`default_nettype none

package rvPipePkg;

	localparam int wordAddrW = 30; // Both memory ports are word addressed

	localparam logic [31:0] nopInst = 32'h0000_0013; // ADDI x0, x0, 0

	// Memory words hold bytes in reverse of register order
	function automatic logic [rvIsaPkg::xlen-1:0] byteSwap(input logic [rvIsaPkg::xlen-1:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Newest value of a source register, memory stage before write-back
	function automatic logic [rvIsaPkg::xlen-1:0] fwdOperand(
		input logic [rvIsaPkg::regAddrW-1:0] rs,
		input logic [rvIsaPkg::xlen-1:0]     regVal,
		input logic                          memRegWrite,
		input logic [rvIsaPkg::regAddrW-1:0] memRd,
		input logic [rvIsaPkg::xlen-1:0]     memResult,
		input logic                          wbRegWrite,
		input logic [rvIsaPkg::regAddrW-1:0] wbRd,
		input logic [rvIsaPkg::xlen-1:0]     wbData
	);
		if (memRegWrite && memRd != '0 && memRd == rs) begin
			return memResult;
		end else if (wbRegWrite && wbRd != '0 && wbRd == rs) begin
			return wbData;
		end
		return regVal; // x0 and unmatched sources
	endfunction

endpackage

`default_nettype wire

/* hdl/fetchUnit.sv */
// Instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

module fetchUnit #(
	parameter logic [31:0] resetPc = 32'h0000_0000
) (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire                             freeze,
	input  wire                             hazardStall,
	input  wire                             branchTaken,
	input  wire  [rvIsaPkg::xlen-1:0]       branchTarget,
	input  wire  [rvIsaPkg::xlen-1:0]       imemRdata,
	output logic                            imemRead,
	output logic [rvPipePkg::wordAddrW-1:0] imemAddr,
	output logic [rvIsaPkg::xlen-1:0]       idPc,
	output logic [31:0]                     idInst
);
	import rvIsaPkg::*;
	import rvPipePkg::*;

	logic [xlen-1:0] pc;
	logic [xlen-1:0] pcNext;
	logic            hold;

	assign hold     = freeze | hazardStall; // Memory stall or decode hazard
	assign pcNext   = branchTaken ? branchTarget : pc + 32'd4;
	assign imemRead = rst_n;
	assign imemAddr = pc[xlen-1:2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= resetPc;
		end else if (!hold) begin
			pc <= pcNext;
		end
	end

	// Fetch/decode register, the slot behind a taken branch becomes a NOP
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idInst <= nopInst;
		end else if (!hold) begin
			idInst <= branchTaken ? nopInst : byteSwap(imemRdata);
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			idPc <= pc;
		end
	end

endmodule

`default_nettype wire

/* hdl/decodeUnit.sv */
// Instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module decodeUnit (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire  [rvIsaPkg::xlen-1:0]     idPc,
	input  wire  [31:0]                   idInst,
	input  wire  [rvIsaPkg::regAddrW-1:0] exRd,
	input  wire                           exRegWrite,
	input  wire                           exMemRead,
	input  wire  [rvIsaPkg::xlen-1:0]     memResult,
	input  wire  [rvIsaPkg::regAddrW-1:0] memRd,
	input  wire                           memRegWrite,
	input  wire  [rvIsaPkg::xlen-1:0]     wbData,
	input  wire  [rvIsaPkg::regAddrW-1:0] wbRd,
	input  wire                           wbRegWrite,
	output logic                          branchTaken,
	output logic [rvIsaPkg::xlen-1:0]     branchTarget,
	output logic                          hazardStall,
	output logic                          bubble,
	output logic [rvIsaPkg::xlen-1:0]     idRs1Data,
	output logic [rvIsaPkg::xlen-1:0]     idRs2Data,
	output logic [rvIsaPkg::xlen-1:0]     idImm,
	output logic [rvIsaPkg::regAddrW-1:0] idRs1,
	output logic [rvIsaPkg::regAddrW-1:0] idRs2,
	output logic [rvIsaPkg::regAddrW-1:0] idRd,
	output rvIsaPkg::aluOpE               idAluOp,
	output logic                          idAluSrc,
	output logic                          idMemRead,
	output logic                          idMemWrite,
	output logic                          idMemToReg,
	output logic                          idRegWrite
);
	import rvIsaPkg::*;
	import rvPipePkg::*;

	opcodeE          opcode;
	logic [2:0]      funct3;
	logic            isBranch;
	logic [xlen-1:0] immI;
	logic [xlen-1:0] immS;
	logic [xlen-1:0] immB;
	logic [xlen-1:0] regs [32];
	logic [xlen-1:0] cmpA;
	logic [xlen-1:0] cmpB;
	logic            condMet;
	logic            exHit;
	logic            wbHit;

	assign opcode = opcodeE'(idInst[6:0]);
	assign funct3 = idInst[14:12];
	assign idRd   = idInst[11:7];
	assign idRs1  = idInst[19:15];
	assign idRs2  = idInst[24:20];

	// ====================================================================
	// Main control
	// ====================================================================
	always_comb begin
		idAluSrc   = 1'b0;
		idMemRead  = 1'b0;
		idMemWrite = 1'b0;
		idMemToReg = 1'b0;
		idRegWrite = 1'b0;
		isBranch   = 1'b0;
		idAluOp    = aluAdd; // Address calculation
		case (opcode)
			opReg: begin
				idRegWrite = 1'b1;
				idAluOp    = aluOpE'({idInst[30], funct3});
			end
			opImm: begin
				idAluSrc   = 1'b1;
				idRegWrite = 1'b1;
				idAluOp    = aluOpE'({idInst[30] & (funct3 == f3Sr), funct3}); // Only SRAI sets bit 3
			end
			opLoad: begin
				idAluSrc   = 1'b1;
				idMemRead  = 1'b1;
				idMemToReg = 1'b1;
				idRegWrite = 1'b1;
			end
			opStore: begin
				idAluSrc   = 1'b1;
				idMemWrite = 1'b1;
			end
			opBranch: isBranch = 1'b1;
			default: ;
		endcase
	end

	// Immediates, shift amounts are zero-extended
	assign immI = (opcode == opImm && (funct3 == 3'b001 || funct3 == f3Sr)) ?
	              {{(xlen-5){1'b0}}, idInst[24:20]} : {{(xlen-12){idInst[31]}}, idInst[31:20]};
	assign immS = {{(xlen-12){idInst[31]}}, idInst[31:25], idInst[11:7]};
	assign immB = {{(xlen-13){idInst[31]}}, idInst[31], idInst[7], idInst[30:25],
	               idInst[11:8], 1'b0};
	assign idImm = (opcode == opStore) ? immS : (opcode == opBranch) ? immB : immI;

	// ====================================================================
	// Register file
	// ====================================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wbRegWrite && wbRd != '0) begin
			regs[wbRd] <= wbData;
		end
	end

	assign idRs1Data = (idRs1 == '0) ? '0 : regs[idRs1];
	assign idRs2Data = (idRs2 == '0) ? '0 : regs[idRs2];

	// Branch compare on forwarded sources
	assign cmpA = fwdOperand(idRs1, idRs1Data, memRegWrite, memRd, memResult,
	                         wbRegWrite, wbRd, wbData);
	assign cmpB = fwdOperand(idRs2, idRs2Data, memRegWrite, memRd, memResult,
	                         wbRegWrite, wbRd, wbData);

	always_comb begin
		case (funct3)
			f3Beq:   condMet = (cmpA == cmpB);
			f3Bne:   condMet = (cmpA != cmpB);
			default: condMet = 1'b0;
		endcase
	end

	assign branchTaken  = isBranch & condMet;
	assign branchTarget = idPc + idImm;

	// Hazards: load-use, same-cycle write-back, branch on result in execute
	assign exHit       = (exRd != '0) && (exRd == idRs1 || exRd == idRs2);
	assign wbHit       = (wbRd != '0) && (wbRd == idRs1 || wbRd == idRs2);
	assign hazardStall = (exMemRead & exHit) | (wbRegWrite & wbHit) |
	                     (isBranch & exRegWrite & exHit);
	assign bubble      = hazardStall;

endmodule

`default_nettype wire

/* hdl/executeUnit.sv */
// Execute stage
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           freeze,
	input  wire                           bubble,
	input  wire  [rvIsaPkg::xlen-1:0]     idRs1Data,
	input  wire  [rvIsaPkg::xlen-1:0]     idRs2Data,
	input  wire  [rvIsaPkg::xlen-1:0]     idImm,
	input  wire  [rvIsaPkg::regAddrW-1:0] idRs1,
	input  wire  [rvIsaPkg::regAddrW-1:0] idRs2,
	input  wire  [rvIsaPkg::regAddrW-1:0] idRd,
	input  var   rvIsaPkg::aluOpE         idAluOp,
	input  wire                           idAluSrc,
	input  wire                           idMemRead,
	input  wire                           idMemWrite,
	input  wire                           idMemToReg,
	input  wire                           idRegWrite,
	input  wire  [rvIsaPkg::xlen-1:0]     memResult,
	input  wire  [rvIsaPkg::regAddrW-1:0] memRd,
	input  wire                           memRegWrite,
	input  wire  [rvIsaPkg::xlen-1:0]     wbData,
	input  wire  [rvIsaPkg::regAddrW-1:0] wbRd,
	input  wire                           wbRegWrite,
	output logic [rvIsaPkg::xlen-1:0]     exResult,
	output logic [rvIsaPkg::xlen-1:0]     exStoreData,
	output logic [rvIsaPkg::regAddrW-1:0] exRd,
	output logic                          exRegWrite,
	output logic                          exMemRead,
	output logic                          exMemWrite,
	output logic                          exMemToReg
);
	import rvIsaPkg::*;
	import rvPipePkg::*;

	logic [xlen-1:0]     rs1Data;
	logic [xlen-1:0]     rs2Data;
	logic [xlen-1:0]     imm;
	logic [regAddrW-1:0] rs1;
	logic [regAddrW-1:0] rs2;
	aluOpE               aluOp;
	logic                aluSrc;
	logic [xlen-1:0]     opA;
	logic [xlen-1:0]     opB;

	// Decode/execute control, a bubble turns the slot into a NOP
	always_ff @(posedge clk) begin
		if (!rst_n || (bubble && !freeze)) begin
			exRd       <= '0;
			exRegWrite <= 1'b0;
			exMemRead  <= 1'b0;
			exMemWrite <= 1'b0;
			exMemToReg <= 1'b0;
		end else if (!freeze) begin
			exRd       <= idRd;
			exRegWrite <= idRegWrite;
			exMemRead  <= idMemRead;
			exMemWrite <= idMemWrite;
			exMemToReg <= idMemToReg;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			rs1Data <= idRs1Data;
			rs2Data <= idRs2Data;
			imm     <= idImm;
			rs1     <= idRs1;
			rs2     <= idRs2;
			aluOp   <= idAluOp;
			aluSrc  <= idAluSrc;
		end
	end

	// Operand forwarding
	assign opA = fwdOperand(rs1, rs1Data, memRegWrite, memRd, memResult,
	                        wbRegWrite, wbRd, wbData);
	assign exStoreData = fwdOperand(rs2, rs2Data, memRegWrite, memRd, memResult,
	                                wbRegWrite, wbRd, wbData);
	assign opB = aluSrc ? imm : exStoreData;

	always_comb begin
		case (aluOp)
			aluSub:  exResult = opA - opB;
			aluSll:  exResult = opA << opB[4:0];
			aluSlt:  exResult = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
			aluXor:  exResult = opA ^ opB;
			aluSrl:  exResult = opA >> opB[4:0];
			aluSra:  exResult = $signed(opA) >>> opB[4:0]; // Keeps the sign bit
			aluOr:   exResult = opA | opB;
			aluAnd:  exResult = opA & opB;
			default: exResult = opA + opB; // ADD, also loads, stores and NOPs
		endcase
	end

endmodule

`default_nettype wire

/* hdl/memWbUnit.sv */
// Memory access and write-back stages
`timescale 1ns/1ps
`default_nettype none

module memWbUnit (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire                             freeze,
	input  wire  [rvIsaPkg::xlen-1:0]       exResult,
	input  wire  [rvIsaPkg::xlen-1:0]       exStoreData,
	input  wire  [rvIsaPkg::regAddrW-1:0]   exRd,
	input  wire                             exRegWrite,
	input  wire                             exMemRead,
	input  wire                             exMemWrite,
	input  wire                             exMemToReg,
	input  wire  [rvIsaPkg::xlen-1:0]       dmemRdata,
	output logic                            dmemRead,
	output logic                            dmemWrite,
	output logic [rvPipePkg::wordAddrW-1:0] dmemAddr,
	output logic [rvIsaPkg::xlen-1:0]       dmemWdata,
	output logic [rvIsaPkg::xlen-1:0]       memResult,
	output logic [rvIsaPkg::regAddrW-1:0]   memRd,
	output logic                            memRegWrite,
	output logic [rvIsaPkg::xlen-1:0]       wbData,
	output logic [rvIsaPkg::regAddrW-1:0]   wbRd,
	output logic                            wbRegWrite
);
	import rvIsaPkg::*;
	import rvPipePkg::*;

	logic [xlen-1:0] memAlu;
	logic            memToReg;
	logic            memWritesReg;
	logic [xlen-1:0] wbAlu;
	logic [xlen-1:0] wbLoad;
	logic            wbMemToReg;

	// ====================================================================
	// Execute/memory register
	// ====================================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dmemRead     <= 1'b0;
			dmemWrite    <= 1'b0;
			memToReg     <= 1'b0;
			memWritesReg <= 1'b0;
			memRd        <= '0;
		end else if (!freeze) begin
			dmemRead     <= exMemRead;
			dmemWrite    <= exMemWrite;
			memToReg     <= exMemToReg;
			memWritesReg <= exRegWrite;
			memRd        <= exRd;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			memAlu    <= exResult;
			dmemWdata <= byteSwap(exStoreData); // Memory byte order
		end
	end

	assign dmemAddr    = memAlu[xlen-1:2];
	assign memResult   = memAlu;
	assign memRegWrite = memWritesReg & ~memToReg; // Load data not ready yet

	// ====================================================================
	// Memory/write-back register
	// ====================================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wbRd       <= '0;
			wbRegWrite <= 1'b0;
			wbMemToReg <= 1'b0;
		end else if (!freeze) begin
			wbRd       <= memRd;
			wbRegWrite <= memWritesReg;
			wbMemToReg <= memToReg;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			wbAlu  <= memAlu;
			wbLoad <= byteSwap(dmemRdata); // Back to register order
		end
	end

	assign wbData = wbMemToReg ? wbLoad : wbAlu;

endmodule

`default_nettype wire

/* hdl/rvCore.sv */
// RV32 five-stage pipeline core
`timescale 1ns/1ps
`default_nettype none

module rvCore #(
	parameter logic [31:0] resetPc = 32'h0000_0000
) (
	input  wire                             clk,
	input  wire                             rst_n,
	output logic                            imemRead,
	output logic [rvPipePkg::wordAddrW-1:0] imemAddr,
	input  wire  [rvIsaPkg::xlen-1:0]       imemRdata,
	input  wire                             imemStall,
	output logic                            dmemRead,
	output logic                            dmemWrite,
	output logic [rvPipePkg::wordAddrW-1:0] dmemAddr,
	output logic [rvIsaPkg::xlen-1:0]       dmemWdata,
	input  wire  [rvIsaPkg::xlen-1:0]       dmemRdata,
	input  wire                             dmemStall
);
	import rvIsaPkg::*;

	logic                freeze;
	logic                hazardStall;
	logic                bubble;
	logic                branchTaken;
	logic [xlen-1:0]     branchTarget;
	logic [xlen-1:0]     idPc;
	logic [31:0]         idInst;

	// Decode outputs
	logic [xlen-1:0]     idRs1Data;
	logic [xlen-1:0]     idRs2Data;
	logic [xlen-1:0]     idImm;
	logic [regAddrW-1:0] idRs1;
	logic [regAddrW-1:0] idRs2;
	logic [regAddrW-1:0] idRd;
	aluOpE               idAluOp;
	logic                idAluSrc;
	logic                idMemRead;
	logic                idMemWrite;
	logic                idMemToReg;
	logic                idRegWrite;

	// Execute outputs
	logic [xlen-1:0]     exResult;
	logic [xlen-1:0]     exStoreData;
	logic [regAddrW-1:0] exRd;
	logic                exRegWrite;
	logic                exMemRead;
	logic                exMemWrite;
	logic                exMemToReg;

	// Forwarding and write-back
	logic [xlen-1:0]     memResult;
	logic [regAddrW-1:0] memRd;
	logic                memRegWrite;
	logic [xlen-1:0]     wbData;
	logic [regAddrW-1:0] wbRd;
	logic                wbRegWrite;

	assign freeze = imemStall | dmemStall; // Whole pipeline waits on either port

	fetchUnit #(.resetPc(resetPc)) uFetch (
		.clk, .rst_n, .freeze, .hazardStall, .branchTaken, .branchTarget,
		.imemRdata, .imemRead, .imemAddr, .idPc, .idInst
	);

	decodeUnit uDecode (
		.clk, .rst_n, .idPc, .idInst, .exRd, .exRegWrite, .exMemRead,
		.memResult, .memRd, .memRegWrite, .wbData, .wbRd, .wbRegWrite,
		.branchTaken, .branchTarget, .hazardStall, .bubble,
		.idRs1Data, .idRs2Data, .idImm, .idRs1, .idRs2, .idRd, .idAluOp,
		.idAluSrc, .idMemRead, .idMemWrite, .idMemToReg, .idRegWrite
	);

	executeUnit uExecute (
		.clk, .rst_n, .freeze, .bubble,
		.idRs1Data, .idRs2Data, .idImm, .idRs1, .idRs2, .idRd, .idAluOp,
		.idAluSrc, .idMemRead, .idMemWrite, .idMemToReg, .idRegWrite,
		.memResult, .memRd, .memRegWrite, .wbData, .wbRd, .wbRegWrite,
		.exResult, .exStoreData, .exRd, .exRegWrite, .exMemRead, .exMemWrite, .exMemToReg
	);

	memWbUnit uMemWb (
		.clk, .rst_n, .freeze,
		.exResult, .exStoreData, .exRd, .exRegWrite, .exMemRead, .exMemWrite, .exMemToReg,
		.dmemRdata, .dmemRead, .dmemWrite, .dmemAddr, .dmemWdata,
		.memResult, .memRd, .memRegWrite, .wbData, .wbRd, .wbRegWrite
	);

endmodule

`default_nettype wire

/* dv/tbClock.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int halfPeriod  = 20,
	parameter int resetCycles = 4
) (
	input  wire  resetReq,
	output logic clk,
	output logic rst_n
);

	initial clk = 1'b0;
	always #halfPeriod clk = ~clk;

	// Power-on reset, then one more reset each time resetReq is raised
	initial begin
		rst_n = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#2 rst_n = 1'b1;
		forever begin
			wait (resetReq);
			@(posedge clk);
			#2 rst_n = 1'b0;
			repeat (resetCycles) @(posedge clk);
			#2 rst_n = 1'b1;
			wait (!resetReq);
		end
	end

endmodule

`default_nettype wire

/* dv/rvCoreTb.sv */
// RV32 pipeline core testbench
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;
	import rvIsaPkg::*;

	localparam int clkPeriod   = 40;
	localparam int storeTotal  = 22;
	localparam int progCycles  = 110; // One program run without stalls, with margin
	localparam int limitCycles = 2 * progCycles * 8;

	// Register-order data of store n at byte address 4*n
	localparam logic [31:0] expData [storeTotal] = '{
		32'h0000_005d, 32'hffff_ff95, 32'h0000_0320, 32'h0000_0001,
		32'h0000_0000, 32'hffff_ff9d, 32'h1fff_ffff, 32'hffff_ffff,
		32'hffff_fffd, 32'h0000_0060, 32'h0000_006b, 32'h0000_0001,
		32'h0000_0640, 32'h0000_000f, 32'hffff_fffc, 32'h0000_0067,
		32'h0000_0009, 32'h0000_006e, 32'h0000_00ba, 32'h0000_0022,
		32'h0000_0064, 32'h0000_0064
	};

	logic        clk;
	logic        rst_n;
	logic        resetReq;
	logic        imemRead;
	logic [29:0] imemAddr;
	logic [31:0] imemRdata;
	logic        imemStall;
	logic        dmemRead;
	logic        dmemWrite;
	logic [29:0] dmemAddr;
	logic [31:0] dmemWdata;
	logic [31:0] dmemRdata;
	logic        dmemStall;

	logic [31:0] imem [64]; // Memory byte order
	logic [31:0] dmem [64];
	int          progLen;
	int          storeCount;
	logic        stallOn;
	logic [31:0] lfsrState;

	tbClock #(.halfPeriod(clkPeriod / 2), .resetCycles(4)) clkGen (
		.resetReq, .clk, .rst_n
	);

	rvCore #(.resetPc(32'h0000_0000)) dut (
		.clk, .rst_n, .imemRead, .imemAddr, .imemRdata, .imemStall,
		.dmemRead, .dmemWrite, .dmemAddr, .dmemWdata, .dmemRdata, .dmemStall
	);

	// ==================================================================
	// Helpers
	// ==================================================================
	function automatic logic [31:0] swapBytes(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] aluReg(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, opReg};
	endfunction

	function automatic logic [31:0] aluImm(input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opImm};
	endfunction

	function automatic logic [31:0] loadWord(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] off);
		return {off, rs1, 3'b010, rd, opLoad};
	endfunction

	function automatic logic [31:0] storeWord(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] off);
		return {off[11:5], rs2, rs1, 3'b010, off[4:0], opStore};
	endfunction

	function automatic logic [31:0] branchIf(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
	endfunction

	task automatic emit(input logic [31:0] inst);
		imem[progLen] = swapBytes(inst); // Stored as the memory sees it
		progLen++;
	endtask

	task automatic valueError(input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[ERROR] %0d ns: %s is %h, expected %h", $time, sig, got, exp);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic stopRun(input string why);
		$display("Error at %0d ns: %s", $time, why);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic fillDataMem();
		for (int i = 0; i < 64; i++) begin
			dmem[i] = 32'hc0de_0000 + i * 32'h0001_0101;
		end
	endtask

	// ==================================================================
	// Memory models and stall source
	// ==================================================================
	always @(posedge clk) begin
		#2;
		if (stallOn) begin
			lfsrState = lfsrStep(lfsrState);
			imemStall = lfsrState[0];
			lfsrState = lfsrStep(lfsrState);
			imemStall = imemStall & lfsrState[0]; // About one cycle in four
			lfsrState = lfsrStep(lfsrState);
			dmemStall = lfsrState[0];
			lfsrState = lfsrStep(lfsrState);
			dmemStall = dmemStall & lfsrState[0];
		end else begin
			imemStall = 1'b0;
			dmemStall = 1'b0;
		end
		imemRdata = imem[imemAddr[5:0]];
		dmemRdata = dmem[dmemAddr[5:0]];
	end

	// Data writes land whenever the data port is not stalled
	always @(negedge clk) begin
		if (rst_n && dmemWrite && !dmemStall) begin
			if (storeCount >= storeTotal) begin
				stopRun("store beyond the expected list, a skipped slot was executed");
			end
			assert (dmemAddr == 30'(storeCount))
				else valueError("dmemAddr", 32'(dmemAddr), 32'(storeCount));
			assert (dmemWdata == swapBytes(expData[storeCount]))
				else valueError("dmemWdata", dmemWdata, swapBytes(expData[storeCount]));
			dmem[dmemAddr[5:0]] = dmemWdata;
			if (!imemStall) begin
				storeCount++; // Store leaves the memory stage
			end
		end
	end

	// ==================================================================
	// Assertions
	// ==================================================================
	assert property (@(negedge clk) !rst_n |-> !dmemRead && !dmemWrite)
		else stopRun("data strobe active during reset");

	assert property (@(negedge clk) $rose(rst_n) |-> !dmemRead && !dmemWrite)
		else stopRun("data strobe active in the first cycle after reset");

	assert property (@(negedge clk) $rose(rst_n) |-> imemAddr == 30'd0)
		else valueError("imemAddr", 32'(imemAddr), 32'd0);

	// Instruction port reads exactly while out of reset
	assert property (@(negedge clk) rst_n |-> imemRead)
		else valueError("imemRead", 32'(imemRead), 32'd1);

	assert property (@(negedge clk) !rst_n |-> !imemRead)
		else valueError("imemRead", 32'(imemRead), 32'd0);

	// Data port frozen while the stall is up
	assert property (@(negedge clk) disable iff (!rst_n)
		$past(dmemStall) |-> $stable(dmemRead) && $stable(dmemWrite))
		else stopRun("data strobes changed during a data stall");

	assert property (@(negedge clk) disable iff (!rst_n)
		$past(dmemStall) |-> $stable(dmemAddr) && $stable(dmemWdata))
		else stopRun("data address or write data changed during a data stall");

	// Watchdog
	initial begin
		repeat (limitCycles) @(posedge clk);
		stopRun("timeout, program did not finish its stores");
	end

	// ==================================================================
	// Program and test sequence
	// ==================================================================
	initial begin
		imemRdata  = '0;
		imemStall  = 1'b0;
		dmemRdata  = '0;
		dmemStall  = 1'b0;
		resetReq   = 1'b0;
		stallOn    = 1'b0;
		storeCount = 0;
		progLen    = 0;
		lfsrState  = 32'h3ca9b5bb;
		for (int i = 0; i < 64; i++) begin
			imem[i] = 32'(i) << 7; // Opcode zero decodes to no operation
		end
		fillDataMem();

		// ALU register forms
		emit(aluImm(3'b000, 5'd1, 5'd0, 12'd100));
		emit(aluImm(3'b000, 5'd2, 5'd0, -12'sd7));
		emit(aluReg(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));  // ADD
		emit(storeWord(5'd3, 5'd0, 12'd0));
		emit(aluReg(7'h20, 3'b000, 5'd4, 5'd2, 5'd1));  // SUB
		emit(storeWord(5'd4, 5'd0, 12'd4));
		emit(aluImm(3'b000, 5'd6, 5'd0, 12'd3));
		emit(aluReg(7'h00, 3'b001, 5'd5, 5'd1, 5'd6));  // SLL
		emit(storeWord(5'd5, 5'd0, 12'd8));
		emit(aluReg(7'h00, 3'b010, 5'd7, 5'd2, 5'd1));  // SLT true
		emit(storeWord(5'd7, 5'd0, 12'd12));
		emit(aluReg(7'h00, 3'b010, 5'd8, 5'd1, 5'd2));  // SLT false
		emit(storeWord(5'd8, 5'd0, 12'd16));
		emit(aluReg(7'h00, 3'b100, 5'd9, 5'd1, 5'd2));  // XOR
		emit(storeWord(5'd9, 5'd0, 12'd20));
		emit(aluReg(7'h00, 3'b101, 5'd10, 5'd2, 5'd6)); // SRL
		emit(storeWord(5'd10, 5'd0, 12'd24));
		emit(aluReg(7'h20, 3'b101, 5'd11, 5'd2, 5'd6)); // SRA
		emit(storeWord(5'd11, 5'd0, 12'd28));
		emit(aluReg(7'h00, 3'b110, 5'd12, 5'd1, 5'd2)); // OR
		emit(storeWord(5'd12, 5'd0, 12'd32));
		emit(aluReg(7'h00, 3'b111, 5'd13, 5'd1, 5'd2)); // AND
		emit(storeWord(5'd13, 5'd0, 12'd36));

		// Immediate forms
		emit(aluImm(3'b100, 5'd14, 5'd1, 12'h00f));
		emit(storeWord(5'd14, 5'd0, 12'd40));
		emit(aluImm(3'b010, 5'd15, 5'd2, -12'sd3));
		emit(storeWord(5'd15, 5'd0, 12'd44));
		emit(aluImm(3'b001, 5'd16, 5'd1, 12'd4));
		emit(storeWord(5'd16, 5'd0, 12'd48));
		emit(aluImm(3'b101, 5'd17, 5'd2, 12'd28));
		emit(storeWord(5'd17, 5'd0, 12'd52));
		emit(aluImm(3'b101, 5'd18, 5'd2, 12'h401));     // SRAI by 1
		emit(storeWord(5'd18, 5'd0, 12'd56));
		emit(aluImm(3'b110, 5'd19, 5'd1, 12'd3));
		emit(storeWord(5'd19, 5'd0, 12'd60));
		emit(aluImm(3'b111, 5'd20, 5'd2, 12'h00f));
		emit(storeWord(5'd20, 5'd0, 12'd64));

		// Dependent chain, load-use, read during write-back
		emit(aluImm(3'b000, 5'd21, 5'd0, 12'd5));
		emit(aluReg(7'h00, 3'b000, 5'd21, 5'd21, 5'd21));
		emit(aluReg(7'h00, 3'b000, 5'd21, 5'd21, 5'd1));
		emit(storeWord(5'd21, 5'd0, 12'd68));
		emit(loadWord(5'd22, 5'd0, 12'd0));
		emit(aluReg(7'h00, 3'b000, 5'd23, 5'd22, 5'd22));
		emit(storeWord(5'd23, 5'd0, 12'd72));
		emit(aluImm(3'b000, 5'd24, 5'd0, 12'd33));
		emit(aluImm(3'b000, 5'd25, 5'd0, 12'd1));
		emit(aluImm(3'b000, 5'd26, 5'd0, 12'd2));
		emit(aluReg(7'h00, 3'b000, 5'd27, 5'd24, 5'd25));
		emit(storeWord(5'd27, 5'd0, 12'd76));

		// Branches with stores at 200 and 204 in skipped slots
		emit(branchIf(f3Beq, 5'd1, 5'd2, 13'd8));
		emit(storeWord(5'd1, 5'd0, 12'd80));
		emit(branchIf(f3Bne, 5'd1, 5'd2, 13'd8));
		emit(storeWord(5'd2, 5'd0, 12'd200));
		emit(aluImm(3'b000, 5'd28, 5'd0, 12'd100));
		emit(branchIf(f3Beq, 5'd28, 5'd1, 13'd8));      // Source from the previous instruction
		emit(storeWord(5'd2, 5'd0, 12'd204));
		emit(branchIf(f3Bne, 5'd28, 5'd1, 13'd8));
		emit(storeWord(5'd28, 5'd0, 12'd84));
		emit(branchIf(f3Beq, 5'd0, 5'd0, 13'd0));       // Self-loop

		// Run without stalls
		wait (rst_n);
		wait (storeCount == storeTotal);
		repeat (20) @(posedge clk);

		// Run again with random stalls on both ports
		resetReq = 1'b1;
		wait (!rst_n);
		resetReq   = 1'b0;
		storeCount = 0;
		fillDataMem();
		wait (rst_n);
		@(posedge clk);
		stallOn = 1'b1;
		wait (storeCount == storeTotal);
		repeat (40) @(posedge clk);

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
hdl/rvIsaPkg.sv
hdl/rvPipePkg.sv
hdl/fetchUnit.sv
hdl/decodeUnit.sv
hdl/executeUnit.sv
hdl/memWbUnit.sv
hdl/rvCore.sv
dv/tbClock.sv
dv/rvCoreTb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - files:
      - hdl/rvIsaPkg.sv
      - hdl/rvPipePkg.sv
      - hdl/fetchUnit.sv
      - hdl/decodeUnit.sv
      - hdl/executeUnit.sv
      - hdl/memWbUnit.sv
      - hdl/rvCore.sv
  - target: simulation
    files:
      - dv/tbClock.sv
      - dv/rvCoreTb.sv
